//--- source/pkt_snoop_pkg.sv
package pkt_snoop_pkg;

    // Word widths on both sides of the width adapter
    localparam int narrow_width = 32;
    localparam int wide_width   = 64;
    localparam int word_ratio   = wide_width / narrow_width;

    // One bank per lane, one packet per bank
    localparam int bank_depth        = 256;
    localparam int wide_addr_width   = 8;
    localparam int narrow_addr_width = 9;

    // Byte count of one wide write, 0 to 8
    localparam int inc_width = 4;

    // Packet length up to 2048 bytes
    localparam int len_width = 12;

    typedef logic [narrow_width-1:0] narrow_word_t;
    typedef logic [wide_width-1:0]   wide_word_t;

    typedef logic [narrow_addr_width-1:0] narrow_addr_t;
    typedef logic [wide_addr_width-1:0]   wide_addr_t;

    typedef logic [inc_width-1:0] byte_inc_t;
    typedef logic [len_width-1:0] pkt_len_t;

endpackage

//--- source/mem_write_if.sv
`timescale 1ns/1ns

interface mem_write_if
    import pkt_snoop_pkg::*;
#(
    parameter type word_t = wide_word_t,
    parameter type addr_t = wide_addr_t
);

    addr_t     addr;
    word_t     data;
    logic      wr_en;
    byte_inc_t byte_inc;
    // Last write of a packet, only valid with wr_en
    logic      done;

    modport source (output addr, data, wr_en, byte_inc, done);
    modport sink   (input  addr, data, wr_en, byte_inc, done);

endinterface

//--- source/stream_snooper.sv
`timescale 1ns/1ns

module stream_snooper
    import pkt_snoop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        s_valid,
    input  logic [7:0]  s_byte,
    input  logic        s_last,
    mem_write_if.source wr
);

    // Bytes already held in the partial word
    logic [1:0]   byte_cnt;
    narrow_word_t word_acc;
    narrow_word_t word_next;
    narrow_addr_t word_addr;
    logic         word_full;

    // First byte of a group lands in the top byte, unused bytes stay zero
    always_comb begin
        if (byte_cnt == 2'd0) begin
            word_next = '0;
        end else begin
            word_next = word_acc;
        end
        word_next[narrow_width-1-8*int'(byte_cnt) -: 8] = s_byte;
    end

    // Four bytes held or packet ends
    assign word_full = (byte_cnt == 2'd3) || s_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt  <= '0;
            word_addr <= '0;
            wr.wr_en  <= 1'b0;
            wr.done   <= 1'b0;
        end else begin
            wr.wr_en <= s_valid && word_full;
            wr.done  <= s_valid && s_last;
            if (s_valid) begin
                if (word_full) begin
                    byte_cnt <= '0;
                    // Next packet starts at the bottom of the bank
                    word_addr <= s_last ? '0 : word_addr + 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // Payload of the narrow write
    always_ff @(posedge clk) begin
        if (s_valid) begin
            word_acc <= word_next;
            if (word_full) begin
                wr.addr     <= word_addr;
                wr.data     <= word_next;
                wr.byte_inc <= byte_inc_t'(byte_cnt) + byte_inc_t'(1);
            end
        end
    end

endmodule

//--- source/width_adapter.sv
`timescale 1ns/1ns

module width_adapter
    import pkt_snoop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    mem_write_if.sink   narrow,
    mem_write_if.source wide
);

    // Slot of the incoming word within the wide word
    logic [narrow_addr_width-wide_addr_width-1:0] sel;

    narrow_word_t stage      [word_ratio];
    narrow_word_t stage_next [word_ratio];
    wide_word_t   wide_data;
    byte_inc_t    inc;

    assign sel = narrow.addr[narrow_addr_width-wide_addr_width-1:0];

    // Even narrow address fills the upper half, so slots run backwards
    always_comb begin
        for (int i = 0; i < word_ratio; i++) begin
            if (word_ratio - 1 - int'(sel) == i) begin
                stage_next[i] = narrow.data;
            end else begin
                stage_next[i] = stage[i];
            end
            wide_data[i*narrow_width +: narrow_width] = stage_next[i];
        end
    end

    always_ff @(posedge clk) begin
        if (narrow.wr_en) begin
            stage <= stage_next;
        end
    end

    // Bytes from narrow writes not yet passed on
    always_ff @(posedge clk) begin
        if (!rst_n || wide.wr_en) begin
            inc <= '0;
        end else if (narrow.wr_en) begin
            inc <= inc + narrow.byte_inc;
        end
    end

    assign wide.addr     = narrow.addr[narrow_addr_width-1 -: wide_addr_width];
    assign wide.data     = wide_data;
    // Write out on a full pair, or early when the packet ends
    assign wide.wr_en    = narrow.wr_en && ((&sel) || narrow.done);
    assign wide.byte_inc = inc + narrow.byte_inc;
    assign wide.done     = narrow.done;

endmodule

//--- source/capture_lane.sv
`timescale 1ns/1ns

module capture_lane
    import pkt_snoop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        s_valid,
    input  logic [7:0]  s_byte,
    input  logic        s_last,
    mem_write_if.source wr
);

    // Snooper to adapter link
    mem_write_if #(
        .word_t (narrow_word_t),
        .addr_t (narrow_addr_t)
    ) narrow_wr ();

    stream_snooper u_snooper (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_byte  (s_byte),
        .s_last  (s_last),
        .wr      (narrow_wr)
    );

    width_adapter u_adapter (
        .clk    (clk),
        .rst_n  (rst_n),
        .narrow (narrow_wr),
        .wide   (wr)
    );

endmodule

//--- source/packet_mem.sv
`timescale 1ns/1ns

module packet_mem
    import pkt_snoop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    mem_write_if.sink  wr0,
    mem_write_if.sink  wr1,
    input  logic       rd_lane,
    input  wide_addr_t rd_addr,
    output wide_word_t rd_data,
    output logic [1:0] done,
    output pkt_len_t   len0,
    output pkt_len_t   len1
);

    // Lane write ports gathered so both banks share one description
    logic [1:0] wr_en;
    logic [1:0] wr_done;
    wide_addr_t wr_addr  [2];
    wide_word_t wr_data  [2];
    byte_inc_t  wr_inc   [2];
    pkt_len_t   lane_len [2];
    wide_word_t lane_rd  [2];
    logic       rd_lane_q;

    assign wr_en      = {wr1.wr_en, wr0.wr_en};
    assign wr_done    = {wr1.done, wr0.done};
    assign wr_addr[0] = wr0.addr;
    assign wr_addr[1] = wr1.addr;
    assign wr_data[0] = wr0.data;
    assign wr_data[1] = wr1.data;
    assign wr_inc[0]  = wr0.byte_inc;
    assign wr_inc[1]  = wr1.byte_inc;

    for (genvar l = 0; l < 2; l++) begin : g_bank
        wide_word_t bank [bank_depth];
        pkt_len_t   total;
        pkt_len_t   sum;
        pkt_len_t   len_q;
        logic       done_q;
        wide_word_t rd_q;

        // Running total including the write in flight
        assign sum = total + pkt_len_t'(wr_inc[l]);

        always_ff @(posedge clk) begin
            if (wr_en[l]) begin
                bank[wr_addr[l]] <= wr_data[l];
            end
            rd_q <= bank[rd_addr];
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                total  <= '0;
                len_q  <= '0;
                done_q <= 1'b0;
            end else begin
                done_q <= wr_en[l] && wr_done[l];
                if (wr_en[l]) begin
                    // Start over for the next packet
                    total <= wr_done[l] ? '0 : sum;
                    if (wr_done[l]) begin
                        len_q <= sum;
                    end
                end
            end
        end

        assign done[l]     = done_q;
        assign lane_len[l] = len_q;
        assign lane_rd[l]  = rd_q;
    end

    always_ff @(posedge clk) begin
        rd_lane_q <= rd_lane;
    end

    assign rd_data = lane_rd[rd_lane_q];
    assign len0    = lane_len[0];
    assign len1    = lane_len[1];

endmodule

//--- source/pkt_snoop_top.sv
`timescale 1ns/1ns

module pkt_snoop_top
    import pkt_snoop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       s0_valid,
    input  logic [7:0] s0_byte,
    input  logic       s0_last,
    input  logic       s1_valid,
    input  logic [7:0] s1_byte,
    input  logic       s1_last,
    input  logic       rd_lane,
    input  wide_addr_t rd_addr,
    output wide_word_t rd_data,
    output logic [1:0] done,
    output pkt_len_t   len0,
    output pkt_len_t   len1
);

    // Wide write ports into the packet buffer
    mem_write_if #(.word_t(wide_word_t), .addr_t(wide_addr_t)) lane0_wr ();
    mem_write_if #(.word_t(wide_word_t), .addr_t(wide_addr_t)) lane1_wr ();

    capture_lane u_lane0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s0_valid),
        .s_byte  (s0_byte),
        .s_last  (s0_last),
        .wr      (lane0_wr)
    );

    capture_lane u_lane1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s1_valid),
        .s_byte  (s1_byte),
        .s_last  (s1_last),
        .wr      (lane1_wr)
    );

    packet_mem u_packet_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr0     (lane0_wr),
        .wr1     (lane1_wr),
        .rd_lane (rd_lane),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .done    (done),
        .len0    (len0),
        .len1    (len1)
    );

endmodule

//--- bench/pkt_snoop_checker.sv
`timescale 1ns/1ns

module pkt_snoop_checker
    import pkt_snoop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] done,
    input  pkt_len_t   len0,
    input  pkt_len_t   len1,
    input  logic       rd_req,
    input  logic       rd_lane,
    input  wide_addr_t rd_addr,
    input  wide_word_t rd_data,
    output int         packets,
    output int         errors
);

    logic [15:0] trace [512];
    // Trace offsets of each lane's records, in arrival order
    int          lane_rec [2][16];
    int          lane_recs [2] = '{0, 0};
    int          lane_next [2] = '{0, 0};
    // Record of the packet that finished last on each lane
    int          cur_rec [2] = '{-1, -1};
    int          pkt_errs [2] = '{0, 0};
    int          pkt_total = 0;
    int          err_total = 0;
    logic        rd_pend = 1'b0;
    logic        pend_lane;
    wide_addr_t  pend_addr;

    assign packets = pkt_total;
    assign errors  = err_total;

    initial begin
        int p;
        int l;
        $readmemh("bench/pkt_snoop_trace.txt", trace);
        p = 0;
        while (trace[p] != 16'h00ff) begin
            l = int'(trace[p+1][0]);
            lane_rec[l][lane_recs[l]] = p;
            lane_recs[l] = lane_recs[l] + 1;
            p = p + 3 + int'(trace[p+2]);
        end
    end

    function automatic int rec_len(input int rec);
        return int'(trace[rec+2]);
    endfunction

    // Byte n of a packet sits in wide word n/8, first byte at the top
    function automatic void expected_word(input int rec, input int w,
                                          output wide_word_t exp_word,
                                          output wide_word_t mask);
        int idx;
        exp_word = '0;
        mask     = '0;
        for (int b = 0; b < 8; b++) begin
            idx = w * 8 + b;
            if (idx < rec_len(rec)) begin
                exp_word[63-8*b -: 8] = trace[rec+3+idx][7:0];
                mask[63-8*b -: 8]     = 8'hff;
            end
        end
    endfunction

    task automatic report_packet(input int l);
        pkt_total = pkt_total + 1;
        $display("Packet %0d on lane %0d, %0d bytes: %0d mismatches",
                 pkt_total, l, rec_len(cur_rec[l]), pkt_errs[l]);
    endtask

    task automatic check_done(input int l);
        pkt_len_t exp_len;
        pkt_len_t got_len;
        if (lane_next[l] >= lane_recs[l]) begin
            $display("Done pulse on lane %0d with no packet left in the trace", l);
            err_total = err_total + 1;
        end else begin
            cur_rec[l]   = lane_rec[l][lane_next[l]];
            lane_next[l] = lane_next[l] + 1;
            pkt_errs[l]  = 0;
            exp_len      = pkt_len_t'(rec_len(cur_rec[l]));
            got_len      = (l == 0) ? len0 : len1;
            if (got_len !== exp_len) begin
                $display("FAILED len%0d expected 0x%h got 0x%h", l, exp_len, got_len);
                pkt_errs[l] = pkt_errs[l] + 1;
                err_total   = err_total + 1;
            end
            // Overwritten by the following packet, so no read-back comes
            if (trace[cur_rec[l]][2]) begin
                report_packet(l);
            end
        end
    endtask

    task automatic check_read();
        int         l;
        int         w;
        wide_word_t exp_word;
        wide_word_t mask;
        l = int'(pend_lane);
        w = int'(pend_addr);
        if (cur_rec[l] < 0) begin
            $display("Read-back from lane %0d before any packet finished there", l);
            err_total = err_total + 1;
        end else begin
            expected_word(cur_rec[l], w, exp_word, mask);
            if ((rd_data & mask) !== exp_word) begin
                $display("FAILED rd_data lane %0d word %0d expected 0x%h got 0x%h",
                         l, w, exp_word, rd_data & mask);
                pkt_errs[l] = pkt_errs[l] + 1;
                err_total   = err_total + 1;
            end
            if (w == (rec_len(cur_rec[l]) + 7) / 8 - 1) begin
                report_packet(l);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int l = 0; l < 2; l++) begin
                if (done[l]) begin
                    check_done(l);
                end
            end
            // Read data shows up one cycle after the request is sampled
            if (rd_pend) begin
                check_read();
            end
        end
        rd_pend   <= rd_req && rst_n;
        pend_lane <= rd_lane;
        pend_addr <= rd_addr;
    end

endmodule

//--- bench/pkt_snoop_tb.sv
`timescale 1ns/1ns

module pkt_snoop_tb
    import pkt_snoop_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        s0_valid;
    logic [7:0]  s0_byte;
    logic        s0_last;
    logic        s1_valid;
    logic [7:0]  s1_byte;
    logic        s1_last;
    logic        rd_req;
    logic        rd_lane;
    wide_addr_t  rd_addr;
    wide_word_t  rd_data;
    logic [1:0]  done;
    pkt_len_t    len0;
    pkt_len_t    len1;
    int          packets;
    int          errors;
    logic [15:0] trace [512];
    logic [31:0] lfsr = 32'hc0a2_a558;
    bit          timed_out = 1'b0;

    pkt_snoop_top u_pkt_snoop_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .s0_valid (s0_valid),
        .s0_byte  (s0_byte),
        .s0_last  (s0_last),
        .s1_valid (s1_valid),
        .s1_byte  (s1_byte),
        .s1_last  (s1_last),
        .rd_lane  (rd_lane),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .done     (done),
        .len0     (len0),
        .len1     (len1)
    );

    pkt_snoop_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .done    (done),
        .len0    (len0),
        .len1    (len1),
        .rd_req  (rd_req),
        .rd_lane (rd_lane),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .packets (packets),
        .errors  (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r    = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    task automatic set_lane(input int lane, input logic valid, input logic [7:0] b,
                            input logic last);
        if (lane == 0) begin
            s0_valid <= valid;
            s0_byte  <= b;
            s0_last  <= last;
        end else begin
            s1_valid <= valid;
            s1_byte  <= b;
            s1_last  <= last;
        end
    endtask

    // Without the tail the lane stays busy for a following packet
    task automatic drive_packet(input int lane, input int start, input int len,
                                input bit gaps, input bit tail);
        int idle;
        for (int i = 0; i < len; i++) begin
            if (gaps) begin
                idle = random_bits(2);
                repeat (idle) begin
                    @(posedge clk);
                    set_lane(lane, 1'b0, 8'h00, 1'b0);
                end
            end
            @(posedge clk);
            set_lane(lane, 1'b1, trace[start+i][7:0], i == len - 1);
        end
        if (tail) begin
            @(posedge clk);
            set_lane(lane, 1'b0, 8'h00, 1'b0);
        end
    endtask

    // Done is sampled mid-cycle where it is stable
    task automatic wait_done(input int lane);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 50 && !seen; i++) begin
            @(negedge clk);
            seen = done[lane];
        end
        if (!seen) begin
            $display("Timeout: no done pulse on lane %0d", lane);
            timed_out = 1'b1;
        end
    endtask

    task automatic read_bank(input int lane, input int len);
        for (int w = 0; w < (len + 7) / 8; w++) begin
            @(posedge clk);
            rd_req  <= 1'b1;
            rd_lane <= lane[0];
            rd_addr <= wide_addr_t'(w);
        end
        @(posedge clk);
        rd_req <= 1'b0;
    endtask

    // Two records on different lanes, driven side by side
    task automatic run_pair(input int a, input int b);
        int lane_a;
        int lane_b;
        int len_a;
        int len_b;
        lane_a = int'(trace[a+1][0]);
        lane_b = int'(trace[b+1][0]);
        len_a  = int'(trace[a+2]);
        len_b  = int'(trace[b+2]);
        fork
            begin
                drive_packet(lane_a, a + 3, len_a, trace[a][0], 1'b1);
                wait_done(lane_a);
            end
            begin
                drive_packet(lane_b, b + 3, len_b, trace[b][0], 1'b1);
                wait_done(lane_b);
            end
        join
        if (!timed_out) begin
            read_bank(lane_a, len_a);
            read_bank(lane_b, len_b);
        end
    endtask

    initial begin
        int p;
        int q;
        int n_recs;
        int flags;
        int lane;
        int len;
        rst_n    = 1'b0;
        s0_valid = 1'b0;
        s0_byte  = 8'h00;
        s0_last  = 1'b0;
        s1_valid = 1'b0;
        s1_byte  = 8'h00;
        s1_last  = 1'b0;
        rd_req   = 1'b0;
        rd_lane  = 1'b0;
        rd_addr  = '0;
        $readmemh("bench/pkt_snoop_trace.txt", trace);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        p      = 0;
        n_recs = 0;
        while (trace[p] != 16'h00ff && !timed_out) begin
            flags  = int'(trace[p]);
            lane   = int'(trace[p+1][0]);
            len    = int'(trace[p+2]);
            q      = p + 3 + len;
            n_recs = n_recs + 1;
            if (flags[1]) begin
                n_recs = n_recs + 1;
                run_pair(p, q);
                p = q + 3 + int'(trace[q+2]);
            end else if (flags[2]) begin
                drive_packet(lane, p + 3, len, flags[0], 1'b0);
                p = q;
            end else begin
                drive_packet(lane, p + 3, len, flags[0], 1'b1);
                wait_done(lane);
                if (!timed_out) begin
                    read_bank(lane, len);
                end
                p = q;
            end
        end

        // Let the last read-back reach the checker
        repeat (4) @(posedge clk);
        $display("%0d of %0d packets checked, %0d errors", packets, n_recs, errors);
        if (timed_out || errors != 0 || packets != n_recs) begin
            if (!timed_out && packets != n_recs) begin
                $display("Some packets were never reported by the checker");
            end
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

//--- bench/pkt_snoop_trace.txt
// Record: flags, lane, length in bytes, then the packet bytes
// Flags: 1 random idle gaps, 2 runs alongside the next record, 4 next record follows at once
0 0 010
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
0 1 00d
3c 1f 72 a5 0e 91 d4 68 b3 27 ca 5e 80
0 0 006
de ad be ef 42 17
// Both lanes at once
2 0 014
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
11 12 13 14
0 1 00b
f0 e1 d2 c3 b4 a5 96 87 78 69 5a
1 1 018
5a a5 c3 3c 69 96 0f f0 12 34 56 78 9a bc de f1
23 45 67 89 ab cd ef 01
// Back to back on lane 0
4 0 009
81 82 83 84 85 86 87 88 89
0 0 011
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0
3 0 007
71 72 73 74 75 76 77
1 1 00c
c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc
ff

//--- pkt_snoop.f
source/pkt_snoop_pkg.sv
source/mem_write_if.sv
source/stream_snooper.sv
source/width_adapter.sv
source/capture_lane.sv
source/packet_mem.sv
source/pkt_snoop_top.sv
bench/pkt_snoop_checker.sv
bench/pkt_snoop_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the packet snooper testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module pkt_snoop_tb \
    -f pkt_snoop.f \
    -Mdir obj_dir -o pkt_snoop_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pkt_snoop_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
